// File: Makefile
VERILATOR    ?= verilator
TOP          := prefetch_buffer_tb
FILELIST     := prefetch_buffer.f
OBJ_DIR      := obj_dir
LOG          := sim.log
PASS_MSG     := Test passed
COMMON_FLAGS := --timing --timescale 1ns/100ps
LINT_FLAGS   := --lint-only -Wall
SIM_FLAGS    := --binary -Wno-fatal --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// log2 of the number of buffered words. Any value from 2 upward works.
`define PREFETCH_DEPTH 4

`define PREFETCH_ENTRIES (1 << `PREFETCH_DEPTH)

// tags hold the word address, bits 31 to 2.
`define FETCH_TAG_W 30

// first address fetched once reset is released.
`define FETCH_RESET_ADDR 32'h0000_0000

`endif

// File: logic/fetch_pkg.sv
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

  // a fetched word is either one 32-bit instruction or two 16-bit parcels.
  typedef union packed {
    logic [31:0] full;
    struct packed {
      logic [15:0] hi;
      logic [15:0] lo;
    } parcels;
  } instr_word_u;

  typedef struct packed {
    logic        valid;
    logic        fence;
    logic [31:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] instr;
  } fetch_rsp_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } imem_rsp_t;

  typedef struct packed {
    logic                    present;
    logic [`FETCH_TAG_W-1:0] tag;
    instr_word_u             data;
  } store_entry_t;

  // sweep writes carry an entry with present cleared.
  typedef struct packed {
    logic                       en;
    logic [`PREFETCH_DEPTH-1:0] idx;
    store_entry_t               entry;
  } store_wr_t;

endpackage

`default_nettype wire

// File: logic/fill_engine.sv
`default_nettype none

`include "fetch_defs.svh"

module fill_engine
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  fetch_req_t  req,
  input  imem_rsp_t   imem_rsp,
  output imem_req_t   imem_req,
  output store_wr_t   wr,
  input  logic        hit,
  input  logic [31:0] miss_addr,
  input  logic [1:0]  consumed,
  output logic        sweeping
);

  localparam int D     = `PREFETCH_DEPTH;
  localparam int CNT_W = D + 1;

  localparam logic [31:0]      RESET_ADDR  = `FETCH_RESET_ADDR;
  localparam logic [D-1:0]     SWEEP_START = RESET_ADDR[D+1:2];
  localparam logic [CNT_W-1:0] AHEAD_MAX   = CNT_W'(2 * (`PREFETCH_ENTRIES - 1));

  logic [31:0]      fetch_addr;
  logic [31:0]      fetch_addr_n;
  logic [CNT_W-1:0] ahead;
  logic [CNT_W-1:0] ahead_n;
  logic [CNT_W-1:0] consumed_ext;
  logic             fetch_valid;
  logic             fetch_valid_n;
  logic             sweeping_n;
  logic             sweep_live;
  logic             sweep_live_n;
  logic [D-1:0]     sweep_idx;
  logic [D-1:0]     sweep_idx_n;
  logic [D-1:0]     sweep_cnt;
  logic [D-1:0]     sweep_cnt_n;
  logic             fetching;
  logic             mem_write;
  logic             can_issue;
  logic             redirect;
  logic             sweep_step;

  // the sweep after reset lets fetching run alongside it. A fence sweep does not.
  assign fetching  = !sweeping || sweep_live;
  assign mem_write = imem_rsp.ready && fetch_valid && fetching;

  // a new address may go out only when nothing is outstanding.
  assign can_issue = !fetch_valid || mem_write;
  assign redirect  = req.valid && !req.fence && !hit && !sweeping && can_issue;

  // a memory word takes the write port and the sweep waits a cycle.
  assign sweep_step   = sweeping && !mem_write;
  assign consumed_ext = CNT_W'(consumed);

  always_comb begin
    fetch_addr_n = fetch_addr;
    ahead_n      = ahead;
    sweeping_n   = sweeping;
    sweep_live_n = sweep_live;
    sweep_idx_n  = sweep_idx;
    sweep_cnt_n  = sweep_cnt;

    if (mem_write) begin
      fetch_addr_n = fetch_addr + 32'd4;
      ahead_n      = ahead + CNT_W'(2);
    end

    // run-ahead is kept in halfwords.
    if (ahead_n >= consumed_ext) begin
      ahead_n = ahead_n - consumed_ext;
    end else begin
      ahead_n = '0;
    end

    if (redirect) begin
      fetch_addr_n = {miss_addr[31:2], 2'b00};
      ahead_n      = '0;
    end

    if (sweep_step) begin
      if (sweep_cnt == '1) begin
        sweeping_n   = 1'b0;
        sweep_live_n = 1'b0;
      end else begin
        sweep_cnt_n = sweep_cnt + 1'b1;
        sweep_idx_n = sweep_idx + 1'b1;
      end
    end

    if (req.valid && req.fence) begin
      sweeping_n   = 1'b1;
      sweep_live_n = 1'b0;
      sweep_idx_n  = SWEEP_START;
      sweep_cnt_n  = '0;
      fetch_addr_n = {req.addr[31:2], 2'b00};
      ahead_n      = '0;
    end

    fetch_valid_n = (!sweeping_n || sweep_live_n) && (ahead_n < AHEAD_MAX);
  end

  always_comb begin
    wr = '0;
    if (mem_write) begin
      wr.en               = 1'b1;
      wr.idx              = fetch_addr[D+1:2];
      wr.entry.present    = 1'b1;
      wr.entry.tag        = fetch_addr[31:2];
      wr.entry.data.full  = imem_rsp.rdata;
    end else if (sweeping) begin
      wr.en  = 1'b1;
      wr.idx = sweep_idx;
    end
  end

  assign imem_req.valid = fetch_valid;
  assign imem_req.addr  = fetch_addr;

  always_ff @(posedge clk) begin
    if (!rst) begin
      fetch_addr  <= RESET_ADDR;
      ahead       <= '0;
      fetch_valid <= 1'b0;
      sweeping    <= 1'b1;
      sweep_live  <= 1'b1;
      sweep_idx   <= SWEEP_START;
      sweep_cnt   <= '0;
    end else begin
      fetch_addr  <= fetch_addr_n;
      ahead       <= ahead_n;
      fetch_valid <= fetch_valid_n;
      sweeping    <= sweeping_n;
      sweep_live  <= sweep_live_n;
      sweep_idx   <= sweep_idx_n;
      sweep_cnt   <= sweep_cnt_n;
    end
  end

endmodule

`default_nettype wire

// File: logic/line_store.sv
`default_nettype none

`include "fetch_defs.svh"

module line_store
  import fetch_pkg::*;
(
  input  logic                       clk,
  input  store_wr_t                  wr,
  input  logic [`PREFETCH_DEPTH-1:0] rd_idx_a,
  input  logic [`PREFETCH_DEPTH-1:0] rd_idx_b,
  output store_entry_t               rd_a,
  output store_entry_t               rd_b
);

  // one entry per buffered word, indexed by the low bits of the word address.
  store_entry_t entries [`PREFETCH_ENTRIES];

  always_ff @(posedge clk) begin
    if (wr.en) begin
      entries[wr.idx] <= wr.entry;
    end
  end

  // both read ports are combinational so the assembler can answer in the
  // same cycle as the request.
  assign rd_a = entries[rd_idx_a];
  assign rd_b = entries[rd_idx_b];

endmodule

`default_nettype wire

// File: logic/parcel_assembler.sv
`default_nettype none

`include "fetch_defs.svh"

module parcel_assembler
  import fetch_pkg::*;
(
  input  fetch_req_t                 req,
  input  store_entry_t               rd_a,
  input  store_entry_t               rd_b,
  input  store_wr_t                  bypass,
  input  logic                       sweeping,
  output logic [`PREFETCH_DEPTH-1:0] rd_idx_a,
  output logic [`PREFETCH_DEPTH-1:0] rd_idx_b,
  output fetch_rsp_t                 rsp,
  output logic                       hit,
  output logic [31:0]                miss_addr,
  output logic [1:0]                 consumed
);

  localparam int D = `PREFETCH_DEPTH;

  logic [`FETCH_TAG_W-1:0] word_a;
  logic [`FETCH_TAG_W-1:0] word_b;
  logic                    a_byp;
  logic                    a_reg;
  logic                    a_ok;
  logic                    b_byp;
  logic                    b_reg;
  logic                    b_ok;
  instr_word_u             a_word;
  instr_word_u             b_word;
  logic [15:0]             first;
  logic                    is_32;
  logic                    need_b;
  logic                    parcels_ok;
  logic [31:0]             instr;
  logic                    ready;

  assign word_a = req.addr[31:2];
  assign word_b = word_a + 1'b1;

  // the second index simply wraps around the store.
  assign rd_idx_a = req.addr[D+1:2];
  assign rd_idx_b = rd_idx_a + 1'b1;

  // a word being written this cycle wins over the stored copy.
  assign a_byp = bypass.en && bypass.entry.present && (bypass.entry.tag == word_a);
  assign b_byp = bypass.en && bypass.entry.present && (bypass.entry.tag == word_b);
  assign a_reg = rd_a.present && (rd_a.tag == word_a);
  assign b_reg = rd_b.present && (rd_b.tag == word_b);

  assign a_ok = a_byp || a_reg;
  assign b_ok = b_byp || b_reg;

  assign a_word = a_byp ? bypass.entry.data : rd_a.data;
  assign b_word = b_byp ? bypass.entry.data : rd_b.data;

  always_comb begin
    if (!req.addr[1]) begin
      first = a_word.parcels.lo;
    end else begin
      first = a_word.parcels.hi;
    end

    // low bits 11 mark a 32-bit instruction.
    is_32 = (first[1:0] == 2'b11);

    // only an upper-half 32-bit instruction reaches into the next word.
    need_b = req.addr[1] && is_32;

    if (!is_32) begin
      instr = {16'h0000, first};
    end else if (!req.addr[1]) begin
      instr = a_word.full;
    end else begin
      instr = {b_word.parcels.lo, first};
    end
  end

  assign parcels_ok = a_ok && (!need_b || b_ok);

  // a fence request is not a fetch and gets no ready.
  assign ready = req.valid && !req.fence && !sweeping && parcels_ok;

  // the first word that is needed and absent.
  assign miss_addr = a_ok ? {word_b, 2'b00} : {word_a, 2'b00};

  always_comb begin
    if (!ready) begin
      consumed = 2'd0;
    end else if (is_32) begin
      consumed = 2'd2;
    end else begin
      consumed = 2'd1;
    end
  end

  assign hit       = ready;
  assign rsp.ready = ready;
  assign rsp.instr = instr;

endmodule

`default_nettype wire

// File: logic/prefetch_buffer.sv
`default_nettype none

`include "fetch_defs.svh"

module prefetch_buffer
  import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  fetch_req_t fetch_req,
  output fetch_rsp_t fetch_rsp,
  output imem_req_t  imem_req,
  input  imem_rsp_t  imem_rsp
);

  store_wr_t                  store_wr;
  store_entry_t               rd_a;
  store_entry_t               rd_b;
  logic [`PREFETCH_DEPTH-1:0] rd_idx_a;
  logic [`PREFETCH_DEPTH-1:0] rd_idx_b;
  logic                       hit;
  logic [31:0]                miss_addr;
  logic [1:0]                 consumed;
  logic                       sweeping;

  line_store u_store (
    .clk      (clk),
    .wr       (store_wr),
    .rd_idx_a (rd_idx_a),
    .rd_idx_b (rd_idx_b),
    .rd_a     (rd_a),
    .rd_b     (rd_b)
  );

  // the fill side's write doubles as the bypass for the output side.
  fill_engine u_fill (
    .clk       (clk),
    .rst       (rst),
    .req       (fetch_req),
    .imem_rsp  (imem_rsp),
    .imem_req  (imem_req),
    .wr        (store_wr),
    .hit       (hit),
    .miss_addr (miss_addr),
    .consumed  (consumed),
    .sweeping  (sweeping)
  );

  parcel_assembler u_asm (
    .req       (fetch_req),
    .rd_a      (rd_a),
    .rd_b      (rd_b),
    .bypass    (store_wr),
    .sweeping  (sweeping),
    .rd_idx_a  (rd_idx_a),
    .rd_idx_b  (rd_idx_b),
    .rsp       (fetch_rsp),
    .hit       (hit),
    .miss_addr (miss_addr),
    .consumed  (consumed)
  );

endmodule

`default_nettype wire

// File: prefetch_buffer.f
+incdir+include
logic/fetch_pkg.sv
logic/line_store.sv
logic/fill_engine.sv
logic/parcel_assembler.sv
logic/prefetch_buffer.sv
verification/tb_clock.sv
verification/imem_model.sv
verification/prefetch_buffer_tb.sv

// File: verification/imem_model.sv
`default_nettype none

module imem_model
  import fetch_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      gen,
  input  logic      wide,
  input  imem_req_t req,
  output imem_rsp_t rsp
);

  timeunit 1ns;
  timeprecision 100ps;

  logic        busy;
  logic [1:0]  delay;
  logic [31:0] addr_q;

  // each word is a fixed function of its address, the generation and the content flag.
  function automatic logic [31:0] content_word(input logic [31:0] addr, input logic g,
                                               input logic w);
    logic [31:0] h;
    h = ({2'b00, addr[31:2]} * 32'h9E37_79B1) ^ (g ? 32'h5AC3_3CA5 : 32'h0000_0000);
    if (w) begin
      return {h[31:18], 2'b11, h[15:2], 2'b11};
    end else begin
      return {h[31:18], 2'b00, h[15:2], 2'b00};
    end
  endfunction

  // one request is served at a time. The ready cycle accepts nothing new
  // because the buffer moves its address on at the end of that cycle.
  always_ff @(posedge clk) begin
    if (!rst) begin
      busy   <= 1'b0;
      delay  <= '0;
      addr_q <= '0;
      rsp    <= '0;
    end else begin
      rsp.ready <= 1'b0;
      if (rsp.ready) begin
        busy <= 1'b0;
      end else if (busy) begin
        if (delay == '0) begin
          rsp.ready <= 1'b1;
          rsp.rdata <= content_word(addr_q, gen, wide);
        end else begin
          delay <= delay - 1'b1;
        end
      end else if (req.valid) begin
        busy   <= 1'b1;
        addr_q <= req.addr;
        delay  <= 2'($urandom_range(2, 0));
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/prefetch_buffer_tb.sv
`default_nettype none

`include "fetch_defs.svh"

module prefetch_buffer_tb
  import fetch_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 400;
  localparam int AHEAD   = `PREFETCH_ENTRIES - 1;

  logic       clk;
  logic       rst;
  logic       gen;
  logic       wide;
  fetch_req_t fetch_req;
  fetch_rsp_t fetch_rsp;
  imem_req_t  imem_req;
  imem_rsp_t  imem_rsp;
  int         errors;
  int         timeouts;

  tb_clock u_clock (.clk(clk), .rst(rst));

  imem_model u_mem (
    .clk(clk), .rst(rst), .gen(gen), .wide(wide), .req(imem_req), .rsp(imem_rsp)
  );

  prefetch_buffer u_dut (
    .clk(clk), .rst(rst), .fetch_req(fetch_req), .fetch_rsp(fetch_rsp),
    .imem_req(imem_req), .imem_rsp(imem_rsp)
  );

  function automatic logic [31:0] rule_word(input logic [31:0] addr, input logic g,
                                            input logic w);
    logic [31:0] h;
    h = ({2'b00, addr[31:2]} * 32'h9E37_79B1) ^ (g ? 32'h5AC3_3CA5 : 32'h0000_0000);
    if (w) begin
      return {h[31:18], 2'b11, h[15:2], 2'b11};
    end else begin
      return {h[31:18], 2'b00, h[15:2], 2'b00};
    end
  endfunction

  // low bits 11 make a 32-bit instruction, which at offset 2 takes the next word's low half.
  function automatic logic [31:0] expect_instr(input logic [31:0] addr, input logic g,
                                               input logic w);
    logic [31:0] cur;
    logic [31:0] nxt;
    logic [15:0] first;
    cur   = rule_word({addr[31:2], 2'b00}, g, w);
    nxt   = rule_word({addr[31:2], 2'b00} + 32'd4, g, w);
    first = addr[1] ? cur[31:16] : cur[15:0];
    if (first[1:0] != 2'b11) begin
      return {16'h0000, first};
    end else if (!addr[1]) begin
      return cur;
    end else begin
      return {nxt[15:0], first};
    end
  endfunction

  task automatic check_fetch(input string what, input logic [31:0] addr,
                             output logic [31:0] got);
    logic [31:0] exp;
    logic        seen;
    int          i;
    exp  = expect_instr(addr, gen, wide);
    seen = 1'b0;
    got  = '0;
    @(negedge clk);
    fetch_req = '{valid: 1'b1, fence: 1'b0, addr: addr};
    for (i = 0; i < TIMEOUT && !seen; i++) begin
      #1;
      if (fetch_rsp.ready) begin
        seen = 1'b1;
        got  = fetch_rsp.instr;
      end else begin
        @(negedge clk);
      end
    end
    @(negedge clk);
    fetch_req.valid = 1'b0;
    assert (seen) else begin
      timeouts++;
      $display("no fetch ready for address %h within %0d cycles", addr, TIMEOUT);
    end
    assert (!seen || got == exp) else begin
      errors++;
      $display("FAILED %0t: %s fetch at %h gave %h, expected %h", $time, what, addr, got, exp);
    end
  endtask

  task automatic fetch_run(input string what, input logic [31:0] start, input int step,
                           input int count);
    logic [31:0] got;
    for (int i = 0; i < count; i++) begin
      check_fetch(what, start + 32'(i * step), got);
    end
  endtask

  task automatic fence_at(input logic [31:0] addr);
    @(negedge clk);
    fetch_req = '{valid: 1'b1, fence: 1'b1, addr: addr};
    @(negedge clk);
    fetch_req = '0;
  endtask

  task automatic sequential_words();
    fetch_run("sequential", 32'h0000_0000, 4, 24);
  endtask

  task automatic halfword_walk();
    wide = 1'b0;
    fence_at(32'h0000_0200);
    fetch_run("halfword", 32'h0000_0200, 2, 40);
  endtask

  // the sixteenth request joins the last store index with index 0.
  task automatic straddle_wrap();
    wide = 1'b1;
    fence_at(32'h0000_0300);
    fetch_run("straddle", 32'h0000_0302, 4, 20);
  endtask

  task automatic far_jump();
    fetch_run("jump", 32'h0001_0400, 4, 9);
  endtask

  task automatic run_ahead_limit();
    logic [31:0] last;
    logic [31:0] top;
    logic [31:0] got;
    int          pulses;
    last   = 32'h0002_0000;
    top    = last;
    pulses = 0;
    check_fetch("run-ahead", last, got);
    // with no requests the engine fills the store and then stops.
    repeat (200) begin
      @(negedge clk);
      #1;
      if (imem_rsp.ready && imem_req.valid) begin
        pulses++;
        if (imem_req.addr > top) begin
          top = imem_req.addr;
        end
      end
    end
    assert (pulses <= AHEAD && (top - last) <= 32'(AHEAD * 4) && !imem_req.valid) else begin
      errors++;
      $display("FAILED %0t: %0d words fetched up to %h past %h, limit %0d words", $time,
               pulses, top, last, AHEAD);
    end
  endtask

  // the run-ahead check leaves the words from 2_0000 upward in the store, so a
  // fence that cleared nothing would hand back their old content.
  task automatic fence_refresh();
    logic [31:0] got;
    logic [31:0] addr;
    gen = ~gen;
    fence_at(32'h0002_0000);
    for (int i = 0; i < 12; i++) begin
      addr = 32'h0002_0000 + 32'(i * 4);
      check_fetch("fence", addr, got);
      assert (got != expect_instr(addr, ~gen, wide)) else begin
        errors++;
        $display("FAILED %0t: word at %h still holds its content from before the fence",
                 $time, addr);
      end
    end
  endtask

  initial begin
    void'($urandom(733));
    errors    = 0;
    timeouts  = 0;
    gen       = 1'b0;
    wide      = 1'b1;
    fetch_req = '0;
    for (int i = 0; i < 20 && rst !== 1'b1; i++) begin
      @(negedge clk);
    end
    assert (rst === 1'b1) else begin
      timeouts++;
      $display("reset was never released");
    end
    sequential_words();
    halfword_walk();
    straddle_wrap();
    far_jump();
    run_ahead_limit();
    fence_refresh();
    $display("summary: %0d value errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset covers the first two rising edges and is released on a falling edge.
  initial begin
    rst = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
  end

endmodule

`default_nettype wire
